// File: rtl/octaPkg.sv
package octaPkg;

  typedef logic [7:0]  wordT;     // Register and ALU data
  typedef logic [15:0] instrT;
  typedef logic [2:0]  regIdxT;
  typedef logic [3:0]  pcT;       // Also the instruction address
  typedef logic [2:0]  opcodeT;   // Instruction bits 2:0
  typedef logic [2:0]  funcT;     // Instruction bits 5:3
  typedef logic [2:0]  aluOpT;
  typedef logic [2:0]  brCondT;   // Same encoding as the B-type func

  typedef enum logic {
    loadIdle,
    loadAcked
  } loadStateT;

  // Major opcodes; L, S and U formats are not implemented
  localparam opcodeT opcReg    = 3'b000;
  localparam opcodeT opcImm    = 3'b001;
  localparam opcodeT opcBranch = 3'b100;
  localparam opcodeT opcJump   = 3'b101;

  localparam aluOpT aluAdd   = 3'b000;  // Add, or subtract with invert
  localparam aluOpT aluLogic = 3'b001;  // NAND, or NOR with invert
  localparam aluOpT aluSltu  = 3'b010;
  localparam aluOpT aluShift = 3'b011;  // SLL, or SRL with invert
  localparam aluOpT aluSra   = 3'b100;

  localparam funcT fnAdd  = 3'b000;
  localparam funcT fnSub  = 3'b001;
  localparam funcT fnNand = 3'b010;
  localparam funcT fnNor  = 3'b011;
  localparam funcT fnSltu = 3'b100;
  localparam funcT fnSll  = 3'b101;
  localparam funcT fnSrl  = 3'b110;
  localparam funcT fnSra  = 3'b111;

  localparam brCondT brEq  = 3'b000;
  localparam brCondT brNe  = 3'b001;
  localparam brCondT brLt  = 3'b010;
  localparam brCondT brLtu = 3'b011;
  localparam brCondT brGe  = 3'b100;
  localparam brCondT brGeu = 3'b101;

  localparam funcT jalFunc = 3'b000;  // Only valid func under opcJump

endpackage

// File: rtl/decodeIf.sv
interface decodeIf;
  octaPkg::aluOpT  aluOp;
  logic            aluInvert;  // Selects the second variant of each ALU class
  logic            srcPc;      // Operand A is pc
  logic            srcImm;     // Operand B is the immediate
  octaPkg::wordT   imm;
  octaPkg::regIdxT rd;
  logic            regWrite;   // Already qualified by rd != 0
  logic            linkPc;     // Write pc+1 instead of the ALU result
  logic            isBranch;
  logic            isJump;
  octaPkg::brCondT brCond;

  modport dec (
    output aluOp, aluInvert, srcPc, srcImm, imm, rd,
    output regWrite, linkPc, isBranch, isJump, brCond
  );

  modport exe (
    input aluOp, aluInvert, srcPc, srcImm, imm, isBranch, isJump, brCond
  );

  modport com (input rd, regWrite, linkPc);

endinterface

// File: rtl/regReadIf.sv
interface regReadIf;
  octaPkg::regIdxT rs1;
  octaPkg::regIdxT rs2;
  octaPkg::wordT   r1;
  octaPkg::wordT   r2;

  // Decode supplies the addresses
  modport dec (output rs1, rs2);

  // Register file answers combinationally
  modport regs (input rs1, rs2, output r1, r2);

  modport exe (input r1, r2);

endinterface

// File: rtl/instrStore.sv
module instrStore #(
  parameter int progDepth = 16
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           run,
  input  logic           loadReq,
  input  octaPkg::pcT    loadAddr,
  input  octaPkg::instrT loadData,
  input  octaPkg::pcT    fetchAddr,
  output logic           loadAck,
  output octaPkg::instrT instr
);

  octaPkg::instrT     mem [progDepth];
  octaPkg::loadStateT state;
  logic               accept;
  logic               inRange;

  // New request taken only while the core is stopped
  assign accept  = (state == octaPkg::loadIdle) && loadReq && !run;
  assign inRange = (int'(loadAddr) < progDepth);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= octaPkg::loadIdle;
    end else begin
      case (state)
        octaPkg::loadIdle: begin
          if (accept) state <= octaPkg::loadAcked;
        end
        octaPkg::loadAcked: begin
          if (!loadReq) state <= octaPkg::loadIdle;  // Phase 4 of the handshake
        end
      endcase
    end
  end

  assign loadAck = (state == octaPkg::loadAcked);

  // Out-of-range words are acked but dropped
  always_ff @(posedge clk) begin
    if (accept && inRange) begin
      mem[loadAddr] <= loadData;
    end
  end

  // Zero word is ADD r0,r0,r0 and does nothing
  assign instr = (int'(fetchAddr) < progDepth) ? mem[fetchAddr] : '0;

endmodule

// File: rtl/instrDecode.sv
module instrDecode (
  input  octaPkg::instrT instr,
  decodeIf.dec           ctl,
  regReadIf.dec          rd
);

  octaPkg::opcodeT opcode;
  octaPkg::funcT   func;
  logic            rdNonZero;

  assign opcode    = instr[2:0];
  assign func      = instr[5:3];
  assign rdNonZero = (instr[8:6] != '0);

  assign ctl.rd     = instr[8:6];
  assign rd.rs1     = instr[11:9];
  assign rd.rs2     = instr[14:12];
  assign ctl.brCond = func;

  // Immediate layout depends on the format
  always_comb begin
    case (opcode)
      octaPkg::opcImm:    ctl.imm = {{5{instr[15]}}, instr[14:12]};
      octaPkg::opcBranch: ctl.imm = {{5{instr[15]}}, instr[8:6]};
      octaPkg::opcJump:   ctl.imm = {1'b0, instr[15:9]};  // Zero-extended
      default:            ctl.imm = '0;
    endcase
  end

  always_comb begin
    ctl.aluOp     = octaPkg::aluAdd;
    ctl.aluInvert = 1'b0;
    ctl.srcPc     = 1'b0;
    ctl.srcImm    = 1'b0;
    ctl.regWrite  = 1'b0;
    ctl.linkPc    = 1'b0;
    ctl.isBranch  = 1'b0;
    ctl.isJump    = 1'b0;
    case (opcode)
      octaPkg::opcReg, octaPkg::opcImm: begin
        ctl.srcImm   = (opcode == octaPkg::opcImm);
        ctl.regWrite = rdNonZero;
        case (func)
          octaPkg::fnSub: begin
            ctl.aluInvert = (opcode == octaPkg::opcReg);  // I-type 001 stays ADDI
          end
          octaPkg::fnNand: ctl.aluOp = octaPkg::aluLogic;
          octaPkg::fnNor: begin
            ctl.aluOp     = octaPkg::aluLogic;
            ctl.aluInvert = 1'b1;
          end
          octaPkg::fnSltu: ctl.aluOp = octaPkg::aluSltu;
          octaPkg::fnSll:  ctl.aluOp = octaPkg::aluShift;
          octaPkg::fnSrl: begin
            ctl.aluOp     = octaPkg::aluShift;
            ctl.aluInvert = 1'b1;
          end
          octaPkg::fnSra:  ctl.aluOp = octaPkg::aluSra;
          default:         ctl.aluOp = octaPkg::aluAdd;  // fnAdd
        endcase
      end
      octaPkg::opcBranch: begin
        ctl.srcPc    = 1'b1;  // Target is pc + imm
        ctl.srcImm   = 1'b1;
        ctl.isBranch = (func <= octaPkg::brGeu);  // Funcs 6 and 7 undefined
      end
      octaPkg::opcJump: begin
        if (func == octaPkg::jalFunc) begin
          ctl.srcPc    = 1'b1;
          ctl.srcImm   = 1'b1;
          ctl.linkPc   = 1'b1;
          ctl.regWrite = rdNonZero;
          ctl.isJump   = 1'b1;
        end
      end
      default: ;  // Unknown opcode is a no-op
    endcase
  end

endmodule

// File: rtl/execUnit.sv
module execUnit (
  input  octaPkg::pcT   pc,
  decodeIf.exe          ctl,
  regReadIf.exe         ops,
  output octaPkg::wordT aluResult,
  output logic          redirect
);

  octaPkg::wordT opA;
  octaPkg::wordT opB;
  octaPkg::wordT addB;
  octaPkg::wordT sum;
  logic [2:0]    shamt;
  logic [8:0]    diff;
  logic          isEq;
  logic          isLt;
  logic          isLtu;
  logic          condTrue;

  assign opA   = ctl.srcPc ? octaPkg::wordT'(pc) : ops.r1;
  assign opB   = ctl.srcImm ? ctl.imm : ops.r2;
  assign shamt = opB[2:0];

  // Invert plus carry-in gives two's-complement subtract
  assign addB = ctl.aluInvert ? ~opB : opB;
  assign sum  = opA + addB + octaPkg::wordT'(ctl.aluInvert);

  always_comb begin
    case (ctl.aluOp)
      octaPkg::aluAdd:   aluResult = sum;
      octaPkg::aluLogic: aluResult = ctl.aluInvert ? ~(opA | opB) : ~(opA & opB);
      octaPkg::aluSltu:  aluResult = (opA < opB) ? octaPkg::wordT'(1) : '0;
      octaPkg::aluShift: aluResult = ctl.aluInvert ? (opA >> shamt) : (opA << shamt);
      octaPkg::aluSra:   aluResult = octaPkg::wordT'($signed(opA) >>> shamt);
      default:           aluResult = '0;
    endcase
  end

  // Branch compare always on the registers, ALU busy with the target
  assign diff  = {1'b0, ops.r1} - {1'b0, ops.r2};
  assign isEq  = (diff[7:0] == '0);
  assign isLtu = diff[8];  // Borrow out
  assign isLt  = (ops.r1[7] ^ ops.r2[7]) ? ops.r1[7] : diff[8];

  always_comb begin
    case (ctl.brCond)
      octaPkg::brEq:  condTrue = isEq;
      octaPkg::brNe:  condTrue = !isEq;
      octaPkg::brLt:  condTrue = isLt;
      octaPkg::brLtu: condTrue = isLtu;
      octaPkg::brGe:  condTrue = !isLt;
      octaPkg::brGeu: condTrue = !isLtu;
      default:        condTrue = 1'b0;
    endcase
  end

  assign redirect = ctl.isJump | (ctl.isBranch & condTrue);

endmodule

// File: rtl/commitUnit.sv
module commitUnit (
  input  logic            clk,
  input  logic            rst,
  input  logic            run,
  input  octaPkg::wordT   aluResult,
  input  logic            redirect,
  decodeIf.com            ctl,
  regReadIf.regs          ops,
  output octaPkg::pcT     pc,
  output logic            commitValid,
  output octaPkg::regIdxT commitReg,
  output octaPkg::wordT   commitData
);

  octaPkg::wordT regFile [8];
  octaPkg::pcT   pcInc;
  octaPkg::wordT wbData;

  assign pcInc  = pc + 1'b1;
  assign wbData = ctl.linkPc ? octaPkg::wordT'(pcInc) : aluResult;  // JAL link

  // r0 is hardwired to zero on read
  assign ops.r1 = (ops.rs1 == '0) ? '0 : regFile[ops.rs1];
  assign ops.r2 = (ops.rs2 == '0) ? '0 : regFile[ops.rs2];

  assign commitValid = run & ctl.regWrite;
  assign commitReg   = ctl.rd;
  assign commitData  = wbData;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      regFile <= '{default: '0};
    end else if (commitValid) begin
      regFile[ctl.rd] <= wbData;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= '0;
    end else if (!run) begin
      pc <= '0;  // Restart from word 0 on every run
    end else if (redirect) begin
      pc <= aluResult[3:0];  // Target wraps in the 16-word space
    end else begin
      pc <= pcInc;
    end
  end

endmodule

// File: rtl/octaCore.sv
module octaCore #(
  parameter int progDepth = 16
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            run,
  input  logic            loadReq,
  input  octaPkg::pcT     loadAddr,
  input  octaPkg::instrT  loadData,
  output logic            loadAck,
  output octaPkg::pcT     pc,
  output logic            commitValid,
  output octaPkg::regIdxT commitReg,
  output octaPkg::wordT   commitData
);

  octaPkg::instrT instr;
  octaPkg::wordT  aluResult;
  logic           redirect;

  decodeIf  ctlBus ();
  regReadIf regBus ();

  instrStore #(
    .progDepth(progDepth)
  ) store (
    .clk      (clk),
    .rst      (rst),
    .run      (run),
    .loadReq  (loadReq),
    .loadAddr (loadAddr),
    .loadData (loadData),
    .fetchAddr(pc),
    .loadAck  (loadAck),
    .instr    (instr)
  );

  instrDecode decode (
    .instr(instr),
    .ctl  (ctlBus.dec),
    .rd   (regBus.dec)
  );

  execUnit exec (
    .pc       (pc),
    .ctl      (ctlBus.exe),
    .ops      (regBus.exe),
    .aluResult(aluResult),
    .redirect (redirect)
  );

  commitUnit commit (
    .clk        (clk),
    .rst        (rst),
    .run        (run),
    .aluResult  (aluResult),
    .redirect   (redirect),
    .ctl        (ctlBus.com),
    .ops        (regBus.regs),
    .pc         (pc),
    .commitValid(commitValid),
    .commitReg  (commitReg),
    .commitData (commitData)
  );

endmodule

// File: verification/octaCore_chk.sv
module octaCore_chk (
  input logic            clk,
  input logic            rst,
  input logic            run,
  input logic            loadReq,
  input logic            loadAck,
  input octaPkg::pcT     pc,
  input logic            commitValid,
  input octaPkg::regIdxT commitReg
);
  timeunit 1ns;
  timeprecision 100ps;

  int assertFails = 0;  // Read by the testbench at the end

  // Ack may only rise after a request seen while stopped
  ackRise: assert property (@(posedge clk) disable iff (rst)
    $rose(loadAck) |-> $past(loadReq && !run))
    else begin
      assertFails++;
      $error("loadAck rose without a request while run was low");
    end

  ackFall: assert property (@(posedge clk) disable iff (rst)
    $fell(loadAck) |-> $past(!loadReq))
    else begin
      assertFails++;
      $error("loadAck fell while loadReq was still high");
    end

  // Stopped core shows no commit and has pc back at 0 one cycle after run drops
  noCommitStopped: assert property (@(posedge clk) disable iff (rst)
    !run |-> (!commitValid && ($past(run) || (pc == '0))))
    else begin
      assertFails++;
      $error("commit or nonzero pc while run is low");
    end

  noCommitR0: assert property (@(posedge clk) disable iff (rst)
    commitValid |-> (commitReg != '0))
    else begin
      assertFails++;
      $error("commit reported for register r0");
    end

endmodule

bind octaCore octaCore_chk chk (
  .clk        (clk),
  .rst        (rst),
  .run        (run),
  .loadReq    (loadReq),
  .loadAck    (loadAck),
  .pc         (pc),
  .commitValid(commitValid),
  .commitReg  (commitReg)
);

// File: verification/octaTb.sv
module octaTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ackLimit   = 16;   // Cycles allowed per handshake edge
  localparam int haltWindow = 32;   // Quiet cycles that end a program
  localparam int runLimit   = 200;

  localparam octaPkg::instrT haltWord = 16'h0004;  // BEQ r0,r0 with offset 0

  logic            clk;
  logic            rst;
  logic            run;
  logic            loadReq;
  octaPkg::pcT     loadAddr;
  octaPkg::instrT  loadData;
  logic            loadAck;
  octaPkg::pcT     pc;
  logic            commitValid;
  octaPkg::regIdxT commitReg;
  octaPkg::wordT   commitData;

  logic [31:0] lfsr;
  int          checkCount;
  int          mismatchCount;
  int          failCount;
  int          expReg[$];
  int          expData[$];
  octaPkg::pcT haltAddr;      // Where the halted core should sit

  octaCore #(
    .progDepth(16)
  ) DUT (
    .clk        (clk),
    .rst        (rst),
    .run        (run),
    .loadReq    (loadReq),
    .loadAddr   (loadAddr),
    .loadData   (loadData),
    .loadAck    (loadAck),
    .pc         (pc),
    .commitValid(commitValid),
    .commitReg  (commitReg),
    .commitData (commitData)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] stepLfsr(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // Galois form
  endfunction

  // Zero to three idle cycles from two LFSR bits
  task automatic idleGap();
    int n;
    n = 0;
    repeat (2) begin
      lfsr = stepLfsr(lfsr);
      n = (n << 1) | int'(lfsr[0]);
    end
    repeat (n) @(posedge clk);
  endtask

  task automatic checkValue(input string name, input logic [15:0] expected,
                            input logic [15:0] actual);
    checkCount++;
    if (expected !== actual) begin
      $display("ERR t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
      mismatchCount++;
    end
  endtask

  task automatic applyReset();
    @(posedge clk);
    rst     <= 1'b1;
    run     <= 1'b0;
    loadReq <= 1'b0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
  endtask

  // One full four-phase transfer
  task automatic loadWord(input octaPkg::pcT addr, input octaPkg::instrT data);
    int waitCount;
    idleGap();
    @(posedge clk);
    loadReq  <= 1'b1;
    loadAddr <= addr;
    loadData <= data;
    waitCount = 0;
    do begin
      @(negedge clk);
      waitCount++;
    end while (!loadAck && waitCount < ackLimit);
    if (!loadAck) begin
      $display("Timed out waiting for loadAck to rise at address %0d", addr);
      failCount++;
    end
    idleGap();
    @(posedge clk);
    loadReq <= 1'b0;
    waitCount = 0;
    do begin
      @(negedge clk);
      waitCount++;
    end while (loadAck && waitCount < ackLimit);
    if (loadAck) begin
      $display("Timed out waiting for loadAck to fall at address %0d", addr);
      failCount++;
    end
  endtask

  // Commits sampled mid-cycle and halt seen as a quiet window
  task automatic runAndCompare();
    int seen;
    int idle;
    int cycles;
    seen   = 0;
    idle   = 0;
    cycles = 0;
    checkValue("pc", 16'h0, pc);  // Held at word 0 while stopped
    @(posedge clk);
    run <= 1'b1;
    while (idle < haltWindow && cycles < runLimit) begin
      @(negedge clk);
      cycles++;
      if (commitValid) begin
        idle = 0;
        if (seen < expReg.size()) begin
          checkValue("commitReg", expReg[seen], commitReg);
          checkValue("commitData", expData[seen], commitData);
        end
        seen++;
      end else begin
        idle++;
      end
    end
    checkValue("pc", haltAddr, pc);
    if (cycles >= runLimit) begin
      $display("Program did not halt within %0d cycles", runLimit);
      failCount++;
    end else if (seen < expReg.size()) begin
      $display("Timed out waiting for commit %0d", seen);
      failCount++;
    end
    checkValue("commitCount", expReg.size(), seen);
    @(posedge clk);
    run <= 1'b0;
  endtask

  initial begin
    string line;
    string tag;
    int    fd;
    int    n;
    int    a;
    int    b;
    int    total;
    rst           = 1'b1;
    run           = 1'b0;
    loadReq       = 1'b0;
    loadAddr      = '0;
    loadData      = '0;
    lfsr          = 32'heada_ad79;
    checkCount    = 0;
    mismatchCount = 0;
    failCount     = 0;
    haltAddr      = '0;
    fd = $fopen("verification/octaVectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file");
      failCount++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        tag  = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 0 && line[0] != "#") begin
          n = $sscanf(line, "%s %h %h", tag, a, b);
          case (tag)
            "T": begin
              expReg.delete();
              expData.delete();
              applyReset();
            end
            "P": begin
              if (octaPkg::instrT'(b) == haltWord) haltAddr = octaPkg::pcT'(a);
              loadWord(octaPkg::pcT'(a), octaPkg::instrT'(b));
            end
            "W": begin
              expReg.push_back(a);
              expData.push_back(b);
            end
            "E": runAndCompare();
            default: ;
          endcase
        end
      end
      $fclose(fd);
    end
    total = mismatchCount + failCount + DUT.chk.assertFails;
    $display("checks %0d, mismatches %0d, other failures %0d, assertion failures %0d",
             checkCount, mismatchCount, failCount, DUT.chk.assertFails);
    if (total == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: verification/octaVectors.txt
# T new program; P addr word (hex); W reg value (hex), expected commit in order; E run
# Word fields: op 2:0, func 5:3, rd 8:6, rs1 11:9, rs2 14:12, sign bit 15
T
P 0 a041
P 1 3081
P 2 22c0
P 3 2308
P 4 2350
P 5 2398
P 6 15e0
P 7 22e8
P 8 2330
P 9 2378
P a 0004
W 1 fa
W 2 03
W 3 fd
W 4 f7
W 5 fd
W 6 04
W 7 01
W 3 d0
W 4 1f
W 5 ff
E
T
P 0 5001
P 1 5041
P 2 d281
P 3 82c9
P 4 f321
P 5 c761
P 6 0785
P 7 11c1
P 8 11c1
P 9 0405
P a 11c1
P b 01d8
P c 0004
W 1 05
W 2 02
W 3 fd
W 4 01
W 5 00
W 6 07
W 7 ff
E
T
P 0 8041
P 1 1081
P 2 1284
P 3 1181
P 4 228c
P 5 1181
P 6 2294
P 7 1181
P 8 149c
P 9 1181
P a 14a4
P b 1181
P c 22ac
P d 1181
P e 21c1
P f 0004
W 1 f8
W 2 01
W 7 02
E
T
P 0 8041
P 1 1081
P 2 23c4
P 3 138c
P 4 1554
P 5 231c
P 6 22e4
P 7 14ac
P 8 31c1
P 9 0004
W 1 f8
W 2 01
W 7 03
E

// File: filelist.f
rtl/octaPkg.sv
rtl/decodeIf.sv
rtl/regReadIf.sv
rtl/instrStore.sv
rtl/instrDecode.sv
rtl/execUnit.sv
rtl/commitUnit.sv
rtl/octaCore.sv
verification/octaCore_chk.sv
verification/octaTb.sv
